//--- project.f
+incdir+bench
src/isa_pkg.sv
src/pipe_pkg.sv
src/dq_write_if.sv
src/inst_decoder.sv
src/opid_allocator.sv
src/decode_queue.sv
src/decode_stage.sv
bench/decode_stage_tb.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - src/isa_pkg.sv
  - src/pipe_pkg.sv
  - src/dq_write_if.sv
  - src/inst_decoder.sv
  - src/opid_allocator.sv
  - src/decode_queue.sv
  - src/decode_stage.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/decode_stage_tb.sv

//--- bench/decode_checks.svh
// compare tasks for the decode stage testbench, typed to the DUT records
// included inside the testbench module, so abort_run and the packages are visible
task automatic flag_mismatch(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    abort_run($sformatf("error at time %0t: %s got %0h expected %0h",
                        $time, name, got, want));
endtask

task automatic verify_opid(input string name, input opid_t got, input opid_t want);
    if (got !== want)
        flag_mismatch(name, got, want);
endtask

task automatic expect_ready(input logic [LANES-1:0] got, input logic [LANES-1:0] want);
    if (got !== want)
        flag_mismatch("ready", got, want);
endtask

task automatic compare_record(input string name, input dec_op_t got, input dec_op_t want);
    if (got.valid !== want.valid)
        flag_mismatch({name, ".valid"}, got.valid, want.valid);
    if (want.valid) begin  // payload is don't care on an empty lane
        verify_opid({name, ".opid"}, got.opid, want.opid);
        if (got.pc !== want.pc)
            flag_mismatch({name, ".pc"}, got.pc, want.pc);
        if (got.unit !== want.unit)
            flag_mismatch({name, ".unit"}, got.unit, want.unit);
        if (got.op !== want.op)
            flag_mismatch({name, ".op"}, got.op, want.op);
        if (got.word !== want.word)
            flag_mismatch({name, ".word"}, got.word, want.word);
        if (got.rs1 !== want.rs1)
            flag_mismatch({name, ".rs1"}, got.rs1, want.rs1);
        if (got.rs2 !== want.rs2)
            flag_mismatch({name, ".rs2"}, got.rs2, want.rs2);
        if (got.rd !== want.rd)
            flag_mismatch({name, ".rd"}, got.rd, want.rd);
        if (got.imm !== want.imm)
            flag_mismatch({name, ".imm"}, got.imm, want.imm);
    end
endtask

//--- bench/decode_stage_tb.sv
// testbench for the two-lane decode stage
// runs an instruction table cycle by cycle against a reference queue and id model
`timescale 1ns/1ps

module decode_stage_tb;
    import pipe_pkg::*;
    import isa_pkg::*;

    logic             clk;
    logic             arst_n;
    logic [LANES-1:0] fetch_valid;
    logic [63:0]      fetch_pc [LANES];
    logic [31:0]      fetch_ir [LANES];
    logic [LANES-1:0] ready;
    logic             redirect;
    lane_cnt_t        commit_count;
    logic [LANES-1:0] decode;
    dec_op_t          out_op [LANES];

    logic [31:0] row_ir [$];   // stimulus words
    dec_op_t     row_exp [$];  // expected records with opid filled at admission
    dec_op_t     ref_q [$];    // model of queue contents
    opid_t       exp_id;
    int          in_flight;
    int          cur;          // next table row fetch offers

    decode_stage decode_stage_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .fetch_ir     (fetch_ir),
        .ready        (ready),
        .redirect     (redirect),
        .commit_count (commit_count),
        .decode       (decode),
        .out_op       (out_op)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    `include "decode_checks.svh"

    task automatic add_row(input logic [31:0] ir, input unit_t u, input op_t o, input logic w,
                           input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd,
                           input logic [63:0] imm);
        dec_op_t rec;

        rec       = '0;
        rec.valid = 1'b1;
        rec.pc    = 64'h8000_0000 + 64'(row_ir.size()) * 4;
        rec.unit  = u;
        rec.op    = o;
        rec.word  = w;
        rec.rs1   = rs1;
        rec.rs2   = rs2;
        rec.rd    = rd;
        rec.imm   = imm;
        row_ir.push_back(ir);
        row_exp.push_back(rec);
    endtask

    task automatic build_table();
        add_row(32'hFFF10093, unit_alu, op_add, 0, 2, 0, 1, 64'hFFFF_FFFF_FFFF_FFFF);  // addi
        add_row(32'h03F21193, unit_alu, op_sll, 0, 4, 0, 3, 64'd63);
        add_row(32'h40135293, unit_alu, op_sra, 0, 6, 0, 5, 64'd1025);
        add_row(32'h00543393, unit_alu, op_sltu, 0, 8, 0, 7, 64'd5);
        add_row(32'hFF85049B, unit_alu, op_add, 1, 10, 0, 9, 64'hFFFF_FFFF_FFFF_FFF8);  // addiw
        add_row(32'h4036559B, unit_alu, op_sra, 1, 12, 0, 11, 64'd1027);
        add_row(32'h800006B7, unit_alu, op_add, 0, 0, 0, 13, 64'hFFFF_FFFF_8000_0000);  // lui
        add_row(32'h12345717, unit_alu, op_add, 0, 0, 0, 14, 64'h1234_5000);  // auipc
        add_row(32'hFFDFF0EF, unit_alu, op_jump, 0, 0, 0, 1, 64'hFFFF_FFFF_FFFF_FFFC);  // jal
        add_row(32'h00008067, unit_alu, op_jump, 0, 1, 0, 0, 64'd0);  // jalr
        add_row(32'h00208463, unit_alu, op_beq, 0, 1, 2, 0, 64'd8);
        add_row(32'hFE41F8E3, unit_alu, op_bgeu, 0, 3, 4, 0, 64'hFFFF_FFFF_FFFF_FFF0);
        add_row(32'h01013783, unit_lsu, op_load, 0, 2, 0, 15, 64'd16);  // ld
        add_row(32'hFFF1C803, unit_lsu, op_load, 0, 3, 0, 16, 64'hFFFF_FFFF_FFFF_FFFF);
        add_row(32'hFE513C23, unit_lsu, op_store, 0, 2, 5, 0, 64'hFFFF_FFFF_FFFF_FFF8);  // sd
        add_row(32'h0263A223, unit_lsu, op_store, 0, 7, 6, 0, 64'd36);
        add_row(32'h413908B3, unit_alu, op_sub, 0, 18, 19, 17, 64'd0);
        add_row(32'h016ABA33, unit_alu, op_sltu, 0, 21, 22, 20, 64'd0);
        add_row(32'h003170B3, unit_alu, op_and, 0, 2, 3, 1, 64'd0);
        add_row(32'h4062D23B, unit_alu, op_sra, 1, 5, 6, 4, 64'd0);  // sraw
        add_row(32'h029403B3, unit_mul, op_mul, 0, 8, 9, 7, 64'd0);
        add_row(32'h02C5A533, unit_mul, op_mulhsu, 0, 11, 12, 10, 64'd0);
        add_row(32'h02F706BB, unit_mul, op_mul, 1, 14, 15, 13, 64'd0);  // mulw
        add_row(32'h0328D833, unit_div, op_divu, 0, 17, 18, 16, 64'd0);
        add_row(32'h035A69BB, unit_div, op_rem, 1, 20, 21, 19, 64'd0);  // remw
        add_row(32'h0FF0000F, unit_lsu, op_fence, 0, 0, 0, 0, 64'd255);
        add_row(32'h0000100F, unit_alu, op_fencei, 0, 0, 0, 0, 64'd0);
        add_row(32'h00000073, unit_alu, op_ecall, 0, 0, 0, 0, 64'd0);
        add_row(32'h00100073, unit_alu, op_ebreak, 0, 0, 0, 0, 64'd0);
        add_row(32'hFFF10090, unit_inv, op_add, 0, 0, 0, 0, 64'd0);  // low bits 00
        add_row(32'h0010808B, unit_inv, op_add, 0, 0, 0, 0, 64'd0);  // custom opcode
        add_row(32'h0220C09B, unit_inv, op_add, 0, 0, 0, 0, 64'd0);  // div funct3 in op-imm-32
    endtask

    // one clock of stimulus on rows cur and cur+1 while the model predicts the response
    task automatic run_cycle(input logic [LANES-1:0] fv, input logic [LANES-1:0] dec,
                             input int commit_req, input logic redir);
        int               c;
        int               row;
        int               space;
        int               credit;
        int               n_out;
        logic             blocked;
        logic             run;
        logic [LANES-1:0] want_ready;
        dec_op_t          want;
        dec_op_t          adm [$];

        @(negedge clk);
        c = (commit_req > in_flight) ? in_flight : commit_req;  // only issued ids return
        for (int i = 0; i < LANES; i++) begin
            row         = (cur + i) % row_ir.size();
            fetch_ir[i] = row_ir[row];
            fetch_pc[i] = row_exp[row].pc;
        end
        fetch_valid  = fv;
        decode       = dec;
        commit_count = lane_cnt_t'(c);
        redirect     = redir;
        #1;
        space      = DQ_DEPTH - ref_q.size();
        credit     = OPID_POOL - in_flight + c;
        blocked    = 1'b0;
        want_ready = '0;
        for (int i = 0; i < LANES; i++) begin
            if (!fv[i]) begin
                want_ready[i] = 1'b1;
            end else if (!blocked && !redir && adm.size() < space && adm.size() < credit) begin
                want      = row_exp[(cur + i) % row_ir.size()];
                want.opid = exp_id + opid_t'(adm.size());
                adm.push_back(want);
                want_ready[i] = 1'b1;
            end else begin
                blocked = 1'b1;  // later lanes wait behind a stalled one
            end
        end
        expect_ready(ready, want_ready);
        run   = 1'b1;
        n_out = 0;
        for (int i = 0; i < LANES; i++) begin
            want = '0;
            if (i < ref_q.size() && !redir)
                want = ref_q[i];
            compare_record($sformatf("out_op[%0d]", i), out_op[i], want);
            if (run && dec[i] && want.valid)
                n_out++;
            else
                run = 1'b0;
        end
        if (redir) begin
            ref_q.delete();
            exp_id    = '0;
            in_flight = 0;
        end else begin
            repeat (n_out) void'(ref_q.pop_front());
            foreach (adm[k])
                ref_q.push_back(adm[k]);
            exp_id    = exp_id + opid_t'(adm.size());
            in_flight = in_flight + adm.size() - c;
            cur       = cur + adm.size();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        @(posedge arst_n);
        repeat (row_ir.size() * 40 + 500) @(posedge clk);  // 40 cycles a row plus setup
        abort_run("timeout: the watchdog expired before all tests finished");
    end

    initial begin
        int hold;

        void'($urandom(32'h0ab8_999b));
        arst_n       = 1'b0;
        fetch_valid  = '0;
        decode       = '0;
        redirect     = 1'b0;
        commit_count = '0;
        for (int i = 0; i < LANES; i++) begin
            fetch_ir[i] = '0;
            fetch_pc[i] = '0;
        end
        cur       = 0;
        in_flight = 0;
        exp_id    = '0;
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        fetch_valid = '1;  // lanes offered while still in reset
        @(negedge clk);
        expect_ready(ready, '1);
        compare_record("out_op[0]", out_op[0], '0);
        compare_record("out_op[1]", out_op[1], '0);
        fetch_valid = '0;
        arst_n      = 1'b1;

        repeat (12) run_cycle(2'b11, 2'b11, 2, 1'b0);  // two lanes until ids wrap past 15
        repeat (4) run_cycle(2'b00, 2'b11, 2, 1'b0);

        cur = 0;
        for (int k = 0; k < row_ir.size(); k++) begin  // each row alone on lane 0
            run_cycle(2'b01, 2'b11, 1, 1'b0);
            run_cycle(2'b00, 2'b11, 1, 1'b0);
        end

        repeat (6) run_cycle(2'b11, 2'b00, 0, 1'b0);  // queue fills to 8
        repeat (6) run_cycle(2'b11, 2'b11, 2, 1'b0);
        repeat (12) run_cycle(2'b11, 2'b11, 0, 1'b0);  // credit runs out at 16
        run_cycle(2'b11, 2'b00, 1, 1'b0);
        run_cycle(2'b11, 2'b00, 2, 1'b0);

        run_cycle(2'b11, 2'b00, 0, 1'b1);  // flush with records queued
        for (int n = 0; n < 6; n++) begin
            hold = $urandom_range(3, 0);
            repeat (hold) run_cycle(2'b11, 2'b00, 0, 1'b0);
            repeat (3) run_cycle(2'b11, 2'b11, 2, 1'b0);
        end
        repeat (8) run_cycle(2'b00, 2'b11, 2, 1'b0);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- src/decode_stage.sv
// two-lane RV64IM decode stage, top level
// per-lane decoders feed in-order admission into the decode queue
`timescale 1ns/1ps

module decode_stage (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [pipe_pkg::LANES-1:0]   fetch_valid,
    input  logic [63:0]                  fetch_pc [pipe_pkg::LANES],
    input  logic [31:0]                  fetch_ir [pipe_pkg::LANES],
    output logic [pipe_pkg::LANES-1:0]   ready,
    input  logic                         redirect,
    input  pipe_pkg::lane_cnt_t          commit_count,
    input  logic [pipe_pkg::LANES-1:0]   decode,
    output pipe_pkg::dec_op_t            out_op [pipe_pkg::LANES]
);
    import pipe_pkg::*;

    dec_op_t dec_rec [LANES];  // raw decoder output, no id yet

    dq_write_if dq_if ();

    for (genvar g = 0; g < LANES; g++) begin : g_lane
        inst_decoder inst_decoder_inst (
            .ir     (fetch_ir[g]),
            .pc     (fetch_pc[g]),
            .op_rec (dec_rec[g])
        );
    end

    opid_allocator opid_allocator_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .fetch_valid  (fetch_valid),
        .rec          (dec_rec),
        .redirect     (redirect),
        .commit_count (commit_count),
        .ready        (ready),
        .dq           (dq_if.alloc)
    );

    decode_queue decode_queue_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .dq       (dq_if.queue),
        .decode   (decode),
        .redirect (redirect),
        .out_op   (out_op)
    );

endmodule

//--- src/decode_queue.sv
// circular decode queue, two write and two read ports
// front entries are presented every cycle, consumed lanes must be leading
`timescale 1ns/1ps

module decode_queue (
    input  logic                         clk,
    input  logic                         arst_n,
    dq_write_if.queue                    dq,
    input  logic [pipe_pkg::LANES-1:0]   decode,
    input  logic                         redirect,
    output pipe_pkg::dec_op_t            out_op [pipe_pkg::LANES]
);
    import pipe_pkg::*;

    dec_op_t                       mem [DQ_DEPTH];
    logic [$clog2(DQ_DEPTH)-1:0]   front;   // oldest entry
    logic [$clog2(DQ_DEPTH)-1:0]   tail;    // first free slot
    dq_cnt_t                       used;    // occupancy
    lane_cnt_t                     n_out;   // entries leaving this cycle

    assign tail    = front + $clog2(DQ_DEPTH)'(used);
    assign dq.free = dq_cnt_t'(DQ_DEPTH) - used;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            out_op[i]       = mem[front + $clog2(DQ_DEPTH)'(i)];
            out_op[i].valid = (i < int'(used)) && !redirect;
        end
    end

    // only a leading run of lanes may leave
    always_comb begin
        logic run;

        run   = 1'b1;
        n_out = '0;
        for (int i = 0; i < LANES; i++) begin
            if (run && decode[i] && out_op[i].valid) begin
                n_out = n_out + 1'b1;
            end else begin
                run = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (i < int'(dq.count)) begin
                mem[tail + $clog2(DQ_DEPTH)'(i)] <= dq.entry[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            front <= '0;
            used  <= '0;
        end else if (dq.flush) begin
            front <= '0;
            used  <= '0;
        end else begin
            front <= front + $clog2(DQ_DEPTH)'(n_out);
            used  <= used + dq.count - n_out;
        end
    end

endmodule

//--- src/opid_allocator.sv
// in-order lane admission against queue space and id credit
// stamps sequential ids on admitted records and tracks ids in flight
`timescale 1ns/1ps

module opid_allocator (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [pipe_pkg::LANES-1:0]   fetch_valid,
    input  pipe_pkg::dec_op_t            rec [pipe_pkg::LANES],
    input  logic                         redirect,
    input  pipe_pkg::lane_cnt_t          commit_count,
    output logic [pipe_pkg::LANES-1:0]   ready,
    dq_write_if.alloc                    dq
);
    import pipe_pkg::*;

    opid_t                              next_id;    // id of next admitted record
    logic [$clog2(OPID_POOL+1)-1:0]     in_flight;  // 0..OPID_POOL
    lane_cnt_t                          adm_cnt;

    always_comb begin
        int n_adm;
        int space;
        int credit;
        logic blocked;

        n_adm   = 0;
        blocked = 1'b0;
        space   = int'(dq.free);
        credit  = OPID_POOL - int'(in_flight) + int'(commit_count);  // returns count this cycle
        ready   = '0;
        for (int i = 0; i < LANES; i++) begin
            dq.entry[i] = '0;
        end
        for (int i = 0; i < LANES; i++) begin
            if (!fetch_valid[i]) begin
                ready[i] = 1'b1;  // empty lane needs nothing
            end else if (!blocked && !redirect && n_adm < space && n_adm < credit) begin
                dq.entry[n_adm]       = rec[i];
                dq.entry[n_adm].valid = 1'b1;
                dq.entry[n_adm].opid  = next_id + opid_t'(n_adm);
                n_adm                 = n_adm + 1;
                ready[i]              = 1'b1;
            end else begin
                blocked = 1'b1;  // later lanes must wait
            end
        end
        adm_cnt  = lane_cnt_t'(n_adm);
        dq.count = adm_cnt;
        dq.flush = redirect;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            next_id   <= '0;
            in_flight <= '0;
        end else if (redirect) begin
            next_id   <= '0;  // restart numbering after flush
            in_flight <= '0;
        end else begin
            next_id   <= next_id + opid_t'(adm_cnt);  // wraps modulo pool size
            in_flight <= in_flight + adm_cnt - commit_count;
        end
    end

endmodule

//--- src/inst_decoder.sv
// decodes one RV64IM instruction word into a decode record
// purely combinational; valid and opid are stamped later at admission
`timescale 1ns/1ps

module inst_decoder (
    input  logic [31:0]       ir,
    input  logic [63:0]       pc,
    output pipe_pkg::dec_op_t op_rec
);
    import isa_pkg::*;

    opcode_t     opc;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    unit_t       dec_unit;
    op_t         dec_op;
    imm_fmt_t    fmt;
    logic        word;
    logic        use_rs1;
    logic        use_rs2;
    logic        use_rd;
    logic [63:0] imm;

    assign opc    = opcode_t'(ir[6:2]);
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];

    always_comb begin
        dec_unit = unit_inv;
        dec_op   = op_add;
        word     = 1'b0;
        fmt      = imm_none;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        use_rd   = 1'b0;
        case (opc)
            opc_lui, opc_auipc: begin
                dec_unit = unit_alu;
                fmt      = imm_u;
                use_rd   = 1'b1;
            end
            opc_jal: begin
                dec_unit = unit_alu;
                dec_op   = op_jump;
                fmt      = imm_j;
                use_rd   = 1'b1;
            end
            opc_jalr: begin
                dec_unit = (funct3 == 3'b000) ? unit_alu : unit_inv;
                dec_op   = op_jump;
                fmt      = imm_i;
                use_rs1  = 1'b1;
                use_rd   = 1'b1;
            end
            opc_branch: begin
                dec_unit = unit_alu;
                fmt      = imm_b;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                case (funct3)
                    3'b000:  dec_op = op_beq;
                    3'b001:  dec_op = op_bne;
                    3'b100:  dec_op = op_blt;
                    3'b101:  dec_op = op_bge;
                    3'b110:  dec_op = op_bltu;
                    3'b111:  dec_op = op_bgeu;
                    default: dec_unit = unit_inv;
                endcase
            end
            opc_load: begin
                dec_unit = (funct3 != 3'b111) ? unit_lsu : unit_inv;  // no 128-bit load
                dec_op   = op_load;
                fmt      = imm_i;
                use_rs1  = 1'b1;
                use_rd   = 1'b1;
            end
            opc_store: begin
                dec_unit = funct3[2] ? unit_inv : unit_lsu;  // sb sh sw sd only
                dec_op   = op_store;
                fmt      = imm_s;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
            end
            opc_op_imm, opc_op_imm_32: begin
                word     = (opc == opc_op_imm_32);
                dec_unit = unit_alu;
                fmt      = imm_i;
                use_rs1  = 1'b1;
                use_rd   = 1'b1;
                case (funct3)
                    3'b000: dec_op = op_add;
                    3'b001: dec_op = op_sll;
                    3'b010: dec_op = op_slt;
                    3'b011: dec_op = op_sltu;
                    3'b100: dec_op = op_xor;
                    3'b101: dec_op = ir[30] ? op_sra : op_srl;
                    3'b110: dec_op = op_or;
                    3'b111: dec_op = op_and;
                endcase
                // shift encodings: 6-bit shamt, word forms 5-bit
                if (funct3 == 3'b001 && (word ? funct7 != 7'd0 : ir[31:26] != 6'd0))
                    dec_unit = unit_inv;
                if (funct3 == 3'b101 && (word ? {funct7[6], funct7[4:0]} != 6'd0
                                              : {ir[31], ir[29:26]} != 5'd0))
                    dec_unit = unit_inv;
                if (word && funct3 != 3'b000 && funct3 != 3'b001 && funct3 != 3'b101)
                    dec_unit = unit_inv;  // only addiw and shifts
            end
            opc_op, opc_op_32: begin
                word    = (opc == opc_op_32);
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_rd  = 1'b1;
                if (funct7 == 7'b0000001) begin
                    dec_unit = funct3[2] ? unit_div : unit_mul;
                    case (funct3)
                        3'b000: dec_op = op_mul;
                        3'b001: dec_op = op_mulh;
                        3'b010: dec_op = op_mulhsu;
                        3'b011: dec_op = op_mulhu;
                        3'b100: dec_op = op_div;
                        3'b101: dec_op = op_divu;
                        3'b110: dec_op = op_rem;
                        3'b111: dec_op = op_remu;
                    endcase
                    if (word && !funct3[2] && funct3[1:0] != 2'b00)
                        dec_unit = unit_inv;  // no mulh* word forms
                end else begin
                    dec_unit = unit_alu;
                    case ({funct7, funct3})
                        10'b0000000_000: dec_op = op_add;
                        10'b0100000_000: dec_op = op_sub;
                        10'b0000000_001: dec_op = op_sll;
                        10'b0000000_010: dec_op = op_slt;
                        10'b0000000_011: dec_op = op_sltu;
                        10'b0000000_100: dec_op = op_xor;
                        10'b0000000_101: dec_op = op_srl;
                        10'b0100000_101: dec_op = op_sra;
                        10'b0000000_110: dec_op = op_or;
                        10'b0000000_111: dec_op = op_and;
                        default:         dec_unit = unit_inv;
                    endcase
                    if (word && funct3 != 3'b000 && funct3 != 3'b001 && funct3 != 3'b101)
                        dec_unit = unit_inv;  // addw subw and shifts only
                end
            end
            opc_misc_mem: begin
                dec_unit = (funct3 == 3'b000) ? unit_lsu
                         : (funct3 == 3'b001) ? unit_alu : unit_inv;
                dec_op   = (funct3 == 3'b000) ? op_fence : op_fencei;
                fmt      = imm_i;  // pred and succ bits
                use_rs1  = 1'b1;
                use_rd   = 1'b1;
            end
            opc_system: begin
                if (ir == 32'h0000_0073) begin
                    dec_unit = unit_alu;
                    dec_op   = op_ecall;
                end else if (ir == 32'h0010_0073) begin
                    dec_unit = unit_alu;
                    dec_op   = op_ebreak;
                end
            end
            default: dec_unit = unit_inv;
        endcase

        // anything unknown, including compressed words, decodes to a bare invalid record
        if (ir[1:0] != 2'b11 || dec_unit == unit_inv) begin
            dec_unit = unit_inv;
            dec_op   = op_add;
            word     = 1'b0;
            fmt      = imm_none;
            use_rs1  = 1'b0;
            use_rs2  = 1'b0;
            use_rd   = 1'b0;
        end
    end

    always_comb begin
        case (fmt)
            imm_i:   imm = {{52{ir[31]}}, ir[31:20]};
            imm_s:   imm = {{52{ir[31]}}, ir[31:25], ir[11:7]};
            imm_b:   imm = {{51{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            imm_u:   imm = {{32{ir[31]}}, ir[31:12], 12'd0};
            imm_j:   imm = {{43{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default: imm = 64'd0;  // register-register forms
        endcase
    end

    always_comb begin
        op_rec      = '0;  // valid and opid left clear
        op_rec.pc   = pc;
        op_rec.unit = dec_unit;
        op_rec.op   = dec_op;
        op_rec.word = word;
        op_rec.rs1  = use_rs1 ? ir[19:15] : 5'd0;
        op_rec.rs2  = use_rs2 ? ir[24:20] : 5'd0;
        op_rec.rd   = use_rd ? ir[11:7] : 5'd0;
        op_rec.imm  = imm;
    end

endmodule

//--- src/dq_write_if.sv
// write channel from lane admission into the decode queue
// entries arrive compacted, count says how many leading ones are written
`timescale 1ns/1ps

interface dq_write_if;
    import pipe_pkg::*;

    dec_op_t   entry [LANES];  // ids already stamped
    lane_cnt_t count;          // leading entries written this cycle
    dq_cnt_t   free;           // free slots in the queue
    logic      flush;          // empty the queue at next edge

    modport alloc (
        output entry,
        output count,
        output flush,
        input  free
    );

    modport queue (
        input  entry,
        input  count,
        input  flush,
        output free
    );

endinterface

//--- src/pipe_pkg.sv
// pipeline-side definitions shared by the decode stage blocks
// lane and queue sizing, id widths and the decoded operation record
package pipe_pkg;

    localparam int LANES     = 2;   // fetch and decode lanes
    localparam int DQ_DEPTH  = 8;   // decode queue entries
    localparam int OPID_POOL = 16;  // ids allowed in flight

    typedef logic [$clog2(OPID_POOL)-1:0] opid_t;
    typedef logic [$clog2(DQ_DEPTH+1)-1:0] dq_cnt_t;  // 0..DQ_DEPTH
    typedef logic [$clog2(LANES+1)-1:0] lane_cnt_t;   // 0..LANES

    // one decoded operation
    typedef struct packed {
        logic           valid;
        opid_t          opid;
        logic [63:0]    pc;
        isa_pkg::unit_t unit;
        isa_pkg::op_t   op;
        logic           word;  // 32-bit form
        logic [4:0]     rs1;
        logic [4:0]     rs2;
        logic [4:0]     rd;
        logic [63:0]    imm;
    } dec_op_t;

endpackage

//--- src/isa_pkg.sv
// encoding-side definitions for RV64IM decode
// major opcodes, unit classes, unit operations and immediate formats
package isa_pkg;

    // major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        opc_load      = 5'b00000,
        opc_misc_mem  = 5'b00011,
        opc_op_imm    = 5'b00100,
        opc_auipc     = 5'b00101,
        opc_op_imm_32 = 5'b00110,
        opc_store     = 5'b01000,
        opc_op        = 5'b01100,
        opc_lui       = 5'b01101,
        opc_op_32     = 5'b01110,
        opc_branch    = 5'b11000,
        opc_jalr      = 5'b11001,
        opc_jal       = 5'b11011,
        opc_system    = 5'b11100
    } opcode_t;

    typedef enum logic [2:0] {
        unit_none,
        unit_alu,
        unit_lsu,
        unit_mul,
        unit_div,
        unit_inv
    } unit_t;

    typedef enum logic [5:0] {
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,  // branch compares
        op_jump, op_ecall, op_ebreak, op_fence, op_fencei,
        op_load, op_store,
        op_mul, op_mulh, op_mulhsu, op_mulhu,
        op_div, op_divu, op_rem, op_remu
    } op_t;

    typedef enum logic [2:0] {
        imm_none,
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_fmt_t;

endpackage
